/* lcd_bus_pkg.sv */
package lcd_bus_pkg;

    // one byte on the 8080 data pins
    typedef logic [7:0] lcd_byte_t;

    // whole display-side write bus, rdx is tied high on the board
    typedef struct packed {
        // chip select, active low
        logic      csx;
        // low for command byte, high for parameter bytes
        logic      dcx;
        // write strobe, display latches on the rising edge
        logic      wrx;
        lcd_byte_t data;
    } lcd_bus_t;

    // bus between commands
    localparam lcd_bus_t LCD_BUS_IDLE = '{
        csx:  1'b1,
        dcx:  1'b0,
        wrx:  1'b1,
        data: 8'h00
    };

endpackage

/* lcd_cmd_pkg.sv */
package lcd_cmd_pkg;

    // display command code
    typedef logic [7:0] cmd_opcode_t;

    // parameter bytes, first byte in [31:24]
    typedef logic [31:0] param_word_t;

    // number of parameter bytes, anything above four counts as four
    typedef logic [3:0] param_count_t;

    // one host request
    typedef struct packed {
        cmd_opcode_t  opcode;
        param_count_t count;
        param_word_t  params;
    } cmd_req_t;

    // most parameter bytes that fit in one word
    localparam param_count_t PARAM_MAX = 4'd4;

    // known opcodes
    localparam cmd_opcode_t OP_NOP     = 8'h00;
    localparam cmd_opcode_t OP_SWRESET = 8'h01;
    localparam cmd_opcode_t OP_SLPIN   = 8'h10;
    localparam cmd_opcode_t OP_SLPOUT  = 8'h11;
    localparam cmd_opcode_t OP_DISPOFF = 8'h28;
    localparam cmd_opcode_t OP_DISPON  = 8'h29;
    // column and page address windows
    localparam cmd_opcode_t OP_CASET   = 8'h2A;
    localparam cmd_opcode_t OP_PASET   = 8'h2B;
    // memory access
    localparam cmd_opcode_t OP_RAMWR   = 8'h2C;
    localparam cmd_opcode_t OP_RAMRD   = 8'h2E;
    localparam cmd_opcode_t OP_MADCTL  = 8'h36;
    localparam cmd_opcode_t OP_PIXFMT  = 8'h3A;

endpackage

/* lcd_cmd_fifo.sv */
`timescale 1ns/100ps

module lcd_cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  nrst,
    // host side
    input  logic                  in_valid,
    output logic                  in_ready,
    input  lcd_cmd_pkg::cmd_req_t in_req,
    // sequencer side
    output logic                  q_valid,
    input  logic                  q_ready,
    output lcd_cmd_pkg::cmd_req_t q_req
);
    import lcd_cmd_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    cmd_req_t          mem [FIFO_DEPTH];
    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic              full;
    logic              empty;
    logic              push;
    logic              pop;

    // extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign in_ready = !full;
    assign q_valid  = !empty;
    assign q_req    = mem[rd_ptr[ADDR_W-1:0]];

    assign push = in_valid && in_ready;
    assign pop  = q_valid && q_ready;

    // pointers
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= in_req;
        end
    end

endmodule

/* lcd_wait_timer.sv */
`timescale 1ns/100ps

module lcd_wait_timer #(
    parameter int WAIT_CYCLES = 600000
) (
    input  logic clk,
    input  logic nrst,
    // one-cycle load request from the sequencer
    input  logic wait_start,
    output logic waiting
);

    // wide enough to hold WAIT_CYCLES itself
    localparam int CNT_W = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES + 1) : 1;

    localparam logic [CNT_W-1:0] LOAD_VAL = CNT_W'(WAIT_CYCLES);

    logic [CNT_W-1:0] count;

    // high for exactly WAIT_CYCLES cycles after the load
    assign waiting = (count != '0);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count <= '0;
        end else if (wait_start) begin
            count <= LOAD_VAL;
        end else if (waiting) begin
            count <= count - 1'b1;
        end
    end

endmodule

/* lcd_bus_sequencer.sv */
`timescale 1ns/100ps

module lcd_bus_sequencer (
    input  logic                  clk,
    input  logic                  nrst,
    // request side
    input  logic                  q_valid,
    output logic                  q_ready,
    input  lcd_cmd_pkg::cmd_req_t q_req,
    // timer side
    input  logic                  waiting,
    output logic                  wait_start,
    // display side
    output lcd_bus_pkg::lcd_bus_t lcd,
    output logic                  busy
);
    import lcd_bus_pkg::*;
    import lcd_cmd_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        STROBE_LOW,
        STROBE_HIGH,
        FINISH
    } seq_state_t;

    seq_state_t   state;
    seq_state_t   state_d;
    lcd_bus_t     bus_q;
    lcd_bus_t     bus_d;
    param_count_t remaining;
    param_count_t remaining_d;
    cmd_opcode_t  opcode_q;
    cmd_opcode_t  opcode_d;
    param_word_t  params_q;
    param_word_t  params_d;
    logic         accept;

    // parameter bytes per opcode, request count for unknown ones
    function automatic param_count_t table_count(input cmd_opcode_t  op,
                                                 input param_count_t req_count);
        case (op)
            OP_CASET, OP_PASET: begin
                return 4'd4;
            end
            OP_RAMWR, OP_RAMRD: begin
                return 4'd2;
            end
            OP_MADCTL, OP_PIXFMT: begin
                return 4'd1;
            end
            OP_NOP, OP_SWRESET, OP_SLPIN, OP_SLPOUT, OP_DISPOFF, OP_DISPON: begin
                return 4'd0;
            end
            default: begin
                return (req_count > PARAM_MAX) ? PARAM_MAX : req_count;
            end
        endcase
    endfunction

    // commands the display needs settling time after
    function automatic logic needs_wait(input cmd_opcode_t op);
        return (op == OP_SWRESET) || (op == OP_SLPIN) || (op == OP_SLPOUT);
    endfunction

    // take a request only when fully idle, so one at a time
    assign q_ready    = (state == IDLE) && !waiting;
    assign accept     = q_valid && q_ready;
    assign busy       = (state != IDLE) || waiting;
    assign wait_start = (state == FINISH) && needs_wait(opcode_q);
    assign lcd        = bus_q;

    always_comb begin
        state_d     = state;
        bus_d       = bus_q;
        remaining_d = remaining;
        opcode_d    = opcode_q;
        params_d    = params_q;

        case (state)
            IDLE: begin
                if (accept) begin
                    state_d     = SETUP;
                    opcode_d    = q_req.opcode;
                    params_d    = q_req.params;
                    remaining_d = table_count(q_req.opcode, q_req.count);
                    // select the chip and put the opcode out with dcx low
                    bus_d.csx   = 1'b0;
                    bus_d.dcx   = 1'b0;
                    bus_d.wrx   = 1'b1;
                    bus_d.data  = q_req.opcode;
                end
            end
            SETUP: begin
                state_d   = STROBE_LOW;
                bus_d.wrx = 1'b0;
            end
            STROBE_LOW: begin
                // rising wrx latches the byte
                state_d   = STROBE_HIGH;
                bus_d.wrx = 1'b1;
            end
            STROBE_HIGH: begin
                if (remaining != '0) begin
                    // next parameter byte from the top of the word
                    state_d     = STROBE_LOW;
                    bus_d.dcx   = 1'b1;
                    bus_d.wrx   = 1'b0;
                    bus_d.data  = params_q[31:24];
                    params_d    = {params_q[23:0], 8'h00};
                    remaining_d = remaining - 1'b1;
                end else begin
                    state_d = FINISH;
                    bus_d   = LCD_BUS_IDLE;
                end
            end
            FINISH: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
                bus_d   = LCD_BUS_IDLE;
            end
        endcase
    end

    // control and bus pins
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= IDLE;
            bus_q     <= LCD_BUS_IDLE;
            remaining <= '0;
        end else begin
            state     <= state_d;
            bus_q     <= bus_d;
            remaining <= remaining_d;
        end
    end

    // command payload
    always_ff @(posedge clk) begin
        opcode_q <= opcode_d;
        params_q <= params_d;
    end

endmodule

/* lcd_ctrl_top.sv */
`timescale 1ns/100ps

module lcd_ctrl_top #(
    parameter int FIFO_DEPTH  = 4,
    parameter int WAIT_CYCLES = 600000
) (
    input  logic                  clk,
    input  logic                  nrst,
    // host request port
    input  logic                  in_valid,
    output logic                  in_ready,
    input  lcd_cmd_pkg::cmd_req_t in_req,
    // display bus
    output lcd_bus_pkg::lcd_bus_t lcd,
    output logic                  busy
);
    import lcd_cmd_pkg::*;

    logic     q_valid;
    logic     q_ready;
    cmd_req_t q_req;
    logic     wait_start;
    logic     waiting;

    // pending requests
    lcd_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_lcd_cmd_fifo (
        .clk      (clk),
        .nrst     (nrst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_req   (in_req),
        .q_valid  (q_valid),
        .q_ready  (q_ready),
        .q_req    (q_req)
    );

    lcd_bus_sequencer i_lcd_bus_sequencer (
        .clk        (clk),
        .nrst       (nrst),
        .q_valid    (q_valid),
        .q_ready    (q_ready),
        .q_req      (q_req),
        .waiting    (waiting),
        .wait_start (wait_start),
        .lcd        (lcd),
        .busy       (busy)
    );

    // hold-off after reset and sleep commands
    lcd_wait_timer #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) i_lcd_wait_timer (
        .clk        (clk),
        .nrst       (nrst),
        .wait_start (wait_start),
        .waiting    (waiting)
    );

endmodule

/* tb_lcd_ctrl.sv */
`timescale 1ns/100ps

module tb_lcd_ctrl;
    import lcd_bus_pkg::*;
    import lcd_cmd_pkg::*;

    localparam int FIFO_DEPTH  = 4;
    localparam int WAIT_CYCLES = 40;
    localparam int CLK_PERIOD  = 4;
    localparam int N_REQ       = 200;
    // worst command is 14 cycles plus the wait hold-off
    localparam int WATCHDOG_NS = (N_REQ * (14 + WAIT_CYCLES + 1) + 2000) * CLK_PERIOD;

    // one byte as the display latches it
    typedef struct packed {
        logic      dcx;
        lcd_byte_t data;
    } bus_byte_t;

    logic        clk = 1'b0;
    logic        nrst;
    logic        in_valid;
    logic        in_ready;
    cmd_req_t    in_req;
    lcd_bus_t    lcd;
    logic        busy;

    logic [31:0] lfsr_state;
    cmd_req_t    model_q [$];
    bus_byte_t   exp_q [$];
    int          value_errors;
    int          protocol_errors;
    int          accepted;
    int          starts;
    int          cycle;
    int          rise_cycle;
    logic        wait_pending;
    logic        full_seen;
    logic        prev_csx;
    logic        prev_wrx;
    cmd_opcode_t cur_op;

    lcd_ctrl_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) i_lcd_ctrl_top (
        .clk      (clk),
        .nrst     (nrst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_req   (in_req),
        .lcd      (lcd),
        .busy     (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic cmd_opcode_t pick_known_op(input logic [3:0] idx);
        case (idx % 12)
            0:       return OP_NOP;
            1:       return OP_SWRESET;
            2:       return OP_SLPIN;
            3:       return OP_SLPOUT;
            4:       return OP_DISPOFF;
            5:       return OP_DISPON;
            6:       return OP_CASET;
            7:       return OP_PASET;
            8:       return OP_RAMWR;
            9:       return OP_RAMRD;
            10:      return OP_MADCTL;
            default: return OP_PIXFMT;
        endcase
    endfunction

    // parameter bytes the display expects after each opcode
    function automatic int expected_param_count(input cmd_opcode_t op, input param_count_t cnt);
        case (op)
            OP_CASET, OP_PASET:   return 4;
            OP_RAMWR, OP_RAMRD:   return 2;
            OP_MADCTL, OP_PIXFMT: return 1;
            OP_NOP, OP_SWRESET, OP_SLPIN, OP_SLPOUT, OP_DISPOFF, OP_DISPON: return 0;
            default:              return (cnt > 4) ? 4 : int'(cnt);
        endcase
    endfunction

    function automatic logic is_wait_cmd(input cmd_opcode_t op);
        return (op == OP_SWRESET) || (op == OP_SLPIN) || (op == OP_SLPOUT);
    endfunction

    // expand one request into the bytes seen on the bus
    task automatic expand_request(input cmd_req_t req);
        param_word_t w;
        bus_byte_t   b;
        int          n;
        int          k;
        w = req.params;
        n = expected_param_count(req.opcode, req.count);
        b.dcx  = 1'b0;
        b.data = req.opcode;
        exp_q.push_back(b);
        for (k = 0; k < n; k++) begin
            b.dcx  = 1'b1;
            b.data = w[31:24];
            exp_q.push_back(b);
            w = w << 8;
        end
    endtask

    // bus monitor and handshake model on the falling edge
    always @(negedge clk) begin
        bus_byte_t e;
        logic      exp_busy;
        cycle++;
        if (prev_csx && !lcd.csx) begin
            starts++;
            if (model_q.size() == 0) begin
                $display("Command started on the bus with no request pending at %0t", $time);
                protocol_errors++;
            end else begin
                cur_op = model_q[0].opcode;
                expand_request(model_q.pop_front());
            end
            if (wait_pending && (cycle - rise_cycle < WAIT_CYCLES)) begin
                $display("Command started %0d cycles after a wait command, too early",
                         cycle - rise_cycle);
                protocol_errors++;
            end
            wait_pending = 1'b0;
        end
        if (nrst && in_ready != (accepted - starts < FIFO_DEPTH)) begin
            $display("Error: in_ready expected %h, got %h at %0t",
                     accepted - starts < FIFO_DEPTH, in_ready, $time);
            value_errors++;
        end
        if (nrst && !in_ready) begin
            full_seen = 1'b1;
        end
        if (in_valid && in_ready) begin
            model_q.push_back(in_req);
            accepted++;
        end
        if (!prev_wrx && lcd.wrx) begin
            if (exp_q.size() == 0) begin
                $display("Byte written on the bus with none expected at %0t", $time);
                protocol_errors++;
            end else begin
                e = exp_q.pop_front();
                if (lcd.dcx != e.dcx) begin
                    $display("Error: lcd.dcx expected %h, got %h at %0t", e.dcx, lcd.dcx, $time);
                    value_errors++;
                end
                if (lcd.data != e.data) begin
                    $display("Error: lcd.data expected %h, got %h at %0t", e.data, lcd.data, $time);
                    value_errors++;
                end
            end
        end
        if (!lcd.wrx && lcd.csx) begin
            $display("Write strobe low while chip select is high at %0t", $time);
            protocol_errors++;
        end
        if (!prev_csx && lcd.csx) begin
            if (exp_q.size() != 0) begin
                $display("Command ended with %0d bytes missing at %0t", exp_q.size(), $time);
                protocol_errors++;
                exp_q.delete();
            end
            rise_cycle = cycle;
            if (is_wait_cmd(cur_op)) begin
                wait_pending = 1'b1;
            end
        end
        // busy through the command, its end cycle and any hold-off
        exp_busy = !lcd.csx || (cycle - rise_cycle <= (wait_pending ? WAIT_CYCLES : 0));
        if (nrst && busy != exp_busy) begin
            $display("Error: busy expected %h, got %h at %0t", exp_busy, busy, $time);
            value_errors++;
        end
        prev_csx = lcd.csx;
        prev_wrx = lcd.wrx;
    end

    initial begin
        cmd_req_t req;
        int       gap;
        int       i;
        logic     taken;
        nrst = 1'b0;
        in_valid = 1'b0;
        in_req = '0;
        lfsr_state = 32'h939d;
        value_errors = 0;
        protocol_errors = 0;
        accepted = 0;
        starts = 0;
        cycle = 0;
        rise_cycle = 0;
        wait_pending = 1'b0;
        full_seen = 1'b0;
        prev_csx = 1'b1;
        prev_wrx = 1'b1;
        cur_op = OP_NOP;
        repeat (16) @(posedge clk);
        #1 nrst = 1'b1;
        @(negedge clk);
        if (lcd.csx !== 1'b1 || lcd.wrx !== 1'b1 || busy !== 1'b0 || in_ready !== 1'b1) begin
            $display("Error: after reset csx,wrx,busy,in_ready expected %h, got %h",
                     4'b1101, {lcd.csx, lcd.wrx, busy, in_ready});
            value_errors++;
        end
        @(posedge clk);
        #1;
        for (i = 0; i < N_REQ; i++) begin
            gap = take_bits(2);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            // half named opcodes, half anything
            if (take_bits(1)) begin
                req.opcode = pick_known_op(4'(take_bits(4)));
            end else begin
                req.opcode = cmd_opcode_t'(take_bits(8));
            end
            req.count  = param_count_t'(take_bits(4));
            req.params = take_bits(32);
            in_req   = req;
            in_valid = 1'b1;
            taken    = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = in_ready;
                @(posedge clk);
                #1;
            end
            in_valid = 1'b0;
        end
        do begin
            @(negedge clk);
        end while (model_q.size() != 0 || exp_q.size() != 0 || !lcd.csx);
        // hold-off of a final wait command runs out
        repeat (WAIT_CYCLES + 2) @(negedge clk);
        if (busy !== 1'b0) begin
            $display("Error: busy expected %h, got %h at end of run", 1'b0, busy);
            value_errors++;
        end
        if (accepted != N_REQ || starts != N_REQ) begin
            $display("Accepted %0d and started %0d requests out of %0d", accepted, starts, N_REQ);
            protocol_errors++;
        end
        if (!full_seen) begin
            $display("Request queue never filled up");
            protocol_errors++;
        end
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish, %0d of %0d requests started", starts, N_REQ);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("Verification failed");
        $finish;
    end

endmodule

/* sources.f */
lcd_bus_pkg.sv
lcd_cmd_pkg.sv
lcd_cmd_fifo.sv
lcd_wait_timer.sv
lcd_bus_sequencer.sv
lcd_ctrl_top.sv
tb_lcd_ctrl.sv

/* Bender.yml */
package:
  name: lcd_ctrl

sources:
  # packages first
  - lcd_bus_pkg.sv
  - lcd_cmd_pkg.sv
  # design
  - lcd_cmd_fifo.sv
  - lcd_wait_timer.sv
  - lcd_bus_sequencer.sv
  - lcd_ctrl_top.sv
  # testbench
  - target: test
    files:
      - tb_lcd_ctrl.sv
